// File: logic/dcache_pkg.sv
// Data cache widths, CPU address and entry field positions
// Controller state encoding
package dcache_pkg;

    // ------------------------------------------------------------------
    // Geometry
    // ------------------------------------------------------------------
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int NUM_LINES      = 128;

    // Fields of a CPU word address, upper bits above the tag ignored
    localparam int ADDR_OFFSET_LSB = 0;
    localparam int ADDR_OFFSET_MSB = 2;
    localparam int ADDR_INDEX_LSB  = 3;
    localparam int ADDR_INDEX_MSB  = 9;
    localparam int ADDR_TAG_LSB    = 10;
    localparam int ADDR_TAG_MSB    = 25;

    // Stored entry layout, line on top, dirty at bit 0
    localparam int DIRTY_BIT = 0;
    localparam int VALID_BIT = 1;
    localparam int TAG_LSB   = 2;
    localparam int DATA_LSB  = 18;

    // ------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------
    typedef logic [WORD_BITS-1:0]                       word_t;
    typedef logic [31:0]                                cpu_addr_t;
    typedef logic [ADDR_OFFSET_MSB-ADDR_OFFSET_LSB:0]   offset_t;
    typedef logic [ADDR_INDEX_MSB-ADDR_INDEX_LSB:0]     index_t;
    typedef logic [ADDR_TAG_MSB-ADDR_TAG_LSB:0]         tag_t;
    // Word 0 sits in the lowest bits
    typedef logic [WORD_BITS*WORDS_PER_LINE-1:0]        line_t;
    // SDRAM line address, tag above index
    typedef logic [$bits(tag_t)+$bits(index_t)-1:0]     line_addr_t;
    typedef logic [DATA_LSB+WORD_BITS*WORDS_PER_LINE-1:0] entry_t;

    // Controller FSM
    typedef enum logic [3:0] {
        idle,
        lookup_wait,
        lookup_check,
        evict_wait,
        refill_wait,
        respond,
        clear_read,
        clear_wait,
        clear_check,
        clear_evict_wait,
        clear_done
    } ctrl_state_t;

endpackage

// File: logic/line_ram_if.sv
// Port bundle between the cache controller and the line RAM
`timescale 1ns/100ps

interface line_ram_if import dcache_pkg::*; ();

    // Driven by the controller
    index_t addr;
    logic   we;
    entry_t wdata;

    // Registered read data from the RAM
    entry_t rdata;

    modport ctrl (
        output addr,
        output we,
        output wdata,
        input  rdata
    );

    modport ram (
        input  addr,
        input  we,
        input  wdata,
        output rdata
    );

endinterface

// File: logic/mem_cmd_if.sv
// Line command channel between the controller and the SDRAM link
`timescale 1ns/100ps

interface mem_cmd_if import dcache_pkg::*; ();

    // Command, valid/ready
    logic       cmd_valid;
    logic       cmd_ready;
    logic       cmd_we;
    line_addr_t cmd_addr;
    line_t      cmd_wdata;

    // Completion, one-cycle pulse with read line
    logic       done;
    line_t      rdata;

    modport ctrl (
        output cmd_valid,
        input  cmd_ready,
        output cmd_we,
        output cmd_addr,
        output cmd_wdata,
        input  done,
        input  rdata
    );

    modport link (
        input  cmd_valid,
        output cmd_ready,
        input  cmd_we,
        input  cmd_addr,
        input  cmd_wdata,
        output done,
        output rdata
    );

endinterface

// File: logic/line_ram.sv
// Tag, valid, dirty and data store of the data cache
// One read port with one cycle of latency, one write port
`timescale 1ns/100ps

module line_ram import dcache_pkg::*; (
    input logic     clk100,
    line_ram_if.ram ram
);

    // One entry per cache index
    entry_t mem [NUM_LINES];

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------
    always_ff @(posedge clk100) begin
        if (ram.we) begin
            mem[ram.addr] <= ram.wdata;
        end
    end

    // ------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------
    // Old contents are returned when reading and writing the same index
    always_ff @(posedge clk100) begin
        ram.rdata <= mem[ram.addr];
    end

endmodule

// File: logic/sdram_link.sv
// Bridge from the line command channel to the SDRAM controller
// Pulses sdc_start once per command and returns a registered done
`timescale 1ns/100ps

module sdram_link import dcache_pkg::*; (
    input  logic       clk100,
    input  logic       reset,
    mem_cmd_if.link    cmd,
    output logic       sdc_start,
    output logic       sdc_we,
    output line_addr_t sdc_addr,
    output line_t      sdc_data,
    input  logic       sdc_done,
    input  line_t      sdc_q
);

    // High from command transfer until sdc_done
    logic busy;

    // Only an idle link takes a command
    assign cmd.cmd_ready = !busy;

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------
    always_ff @(posedge clk100) begin
        if (reset) begin
            busy      <= 1'b0;
            sdc_start <= 1'b0;
            cmd.done  <= 1'b0;
        end else begin
            // Both pulses last one cycle
            sdc_start <= 1'b0;
            cmd.done  <= 1'b0;
            if (cmd.cmd_valid && cmd.cmd_ready) begin
                busy      <= 1'b1;
                sdc_start <= 1'b1;
            end else if (busy && sdc_done) begin
                busy     <= 1'b0;
                cmd.done <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Command and result holding registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk100) begin
        // Held for the whole SDRAM operation
        if (cmd.cmd_valid && cmd.cmd_ready) begin
            sdc_we   <= cmd.cmd_we;
            sdc_addr <= cmd.cmd_addr;
            sdc_data <= cmd.cmd_wdata;
        end
        // Read line, valid together with done
        if (busy && sdc_done) begin
            cmd.rdata <= sdc_q;
        end
    end

endmodule

// File: logic/dcache_ctrl.sv
// Direct-mapped write-back data cache controller
// Hit check, dirty eviction, refill with write merge, clear walk
`timescale 1ns/100ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic      clk100,
    input  logic      reset,
    // CPU request
    input  logic      req_valid,
    output logic      req_ready,
    input  cpu_addr_t req_addr,
    input  word_t     req_wdata,
    input  logic      req_we,
    // CPU response
    output logic      rsp_valid,
    input  logic      rsp_ready,
    output word_t     rsp_data,
    // Cache clear
    input  logic      clear_valid,
    output logic      clear_ready,
    output logic      clear_done,
    // Line RAM and SDRAM channel
    line_ram_if.ctrl  ram,
    mem_cmd_if.ctrl   mem
);

    ctrl_state_t state;

    // Accepted request
    cpu_addr_t req_addr_q;
    word_t     req_wdata_q;
    logic      req_we_q;
    word_t     rsp_data_q;

    // Clear walk position
    index_t    clear_idx;

    // Fields of the stored request
    offset_t   req_offset;
    index_t    req_index;
    tag_t      req_tag;

    // Fields of the entry read from the line RAM
    logic      rd_valid;
    logic      rd_dirty;
    tag_t      rd_tag;
    line_t     rd_line;

    logic      hit;
    logic      victim_dirty;
    logic      clear_last;

    // ------------------------------------------------------------------
    // Line helpers
    // ------------------------------------------------------------------
    function automatic line_t merge_word(line_t line, offset_t off, word_t data);
        line_t merged;
        merged = line;
        merged[int'(off)*WORD_BITS +: WORD_BITS] = data;
        return merged;
    endfunction

    function automatic word_t pick_word(line_t line, offset_t off);
        return line[int'(off)*WORD_BITS +: WORD_BITS];
    endfunction

    // Always stored valid
    function automatic entry_t make_entry(line_t line, tag_t tag, logic dirty);
        return {line, tag, 1'b1, dirty};
    endfunction

    assign req_offset = req_addr_q[ADDR_OFFSET_MSB:ADDR_OFFSET_LSB];
    assign req_index  = req_addr_q[ADDR_INDEX_MSB:ADDR_INDEX_LSB];
    assign req_tag    = req_addr_q[ADDR_TAG_MSB:ADDR_TAG_LSB];

    assign rd_valid = ram.rdata[VALID_BIT];
    assign rd_dirty = ram.rdata[DIRTY_BIT];
    assign rd_tag   = ram.rdata[TAG_LSB +: $bits(tag_t)];
    assign rd_line  = ram.rdata[DATA_LSB +: $bits(line_t)];

    assign hit          = rd_valid && (rd_tag == req_tag);
    // Also decides write-back during the clear walk
    assign victim_dirty = rd_valid && rd_dirty;
    assign clear_last   = (clear_idx == index_t'(NUM_LINES - 1));

    // Clear wins when both are valid
    assign clear_ready = (state == idle);
    assign req_ready   = (state == idle) && !clear_valid;
    assign rsp_valid   = (state == respond);
    assign rsp_data    = rsp_data_q;
    // Enum literal shares the port name
    assign clear_done  = (state == dcache_pkg::clear_done);

    // ------------------------------------------------------------------
    // Line RAM port
    // ------------------------------------------------------------------
    always_comb begin
        ram.addr  = req_index;
        ram.we    = 1'b0;
        ram.wdata = '0;
        case (state)
            lookup_check: begin
                // Write hit merges into the resident line
                if (hit && req_we_q) begin
                    ram.we    = 1'b1;
                    ram.wdata = make_entry(merge_word(rd_line, req_offset, req_wdata_q),
                                           req_tag, 1'b1);
                end
            end
            refill_wait: begin
                if (mem.done) begin
                    ram.we    = 1'b1;
                    ram.wdata = make_entry(req_we_q ?
                                           merge_word(mem.rdata, req_offset, req_wdata_q) :
                                           mem.rdata, req_tag, req_we_q);
                end
            end
            clear_read, clear_wait: begin
                ram.addr = clear_idx;
            end
            clear_check: begin
                // Clean or invalid entries are zeroed at once
                ram.addr = clear_idx;
                ram.we   = !victim_dirty;
            end
            clear_evict_wait: begin
                ram.addr = clear_idx;
                ram.we   = mem.done;
            end
            default: begin
            end
        endcase
    end

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk100) begin
        if (reset) begin
            state         <= idle;
            mem.cmd_valid <= 1'b0;
            clear_idx     <= '0;
        end else begin
            // Link is idle whenever a command is raised
            if (mem.cmd_valid && mem.cmd_ready) begin
                mem.cmd_valid <= 1'b0;
            end
            case (state)
                idle: begin
                    if (clear_valid) begin
                        clear_idx <= '0;
                        state     <= clear_read;
                    end else if (req_valid) begin
                        state <= lookup_wait;
                    end
                end
                lookup_wait: begin
                    state <= lookup_check;
                end
                lookup_check: begin
                    if (hit) begin
                        state <= respond;
                    end else begin
                        mem.cmd_valid <= 1'b1;
                        state         <= victim_dirty ? evict_wait : refill_wait;
                    end
                end
                evict_wait: begin
                    // Victim written, fetch the requested line
                    if (mem.done) begin
                        mem.cmd_valid <= 1'b1;
                        state         <= refill_wait;
                    end
                end
                refill_wait: begin
                    if (mem.done) begin
                        state <= respond;
                    end
                end
                respond: begin
                    if (rsp_ready) begin
                        state <= idle;
                    end
                end
                clear_read: begin
                    state <= clear_wait;
                end
                clear_wait: begin
                    state <= clear_check;
                end
                clear_check: begin
                    if (victim_dirty) begin
                        mem.cmd_valid <= 1'b1;
                        state         <= clear_evict_wait;
                    end else if (clear_last) begin
                        state <= dcache_pkg::clear_done;
                    end else begin
                        clear_idx <= clear_idx + 1'b1;
                        state     <= clear_read;
                    end
                end
                clear_evict_wait: begin
                    if (mem.done) begin
                        if (clear_last) begin
                            state <= dcache_pkg::clear_done;
                        end else begin
                            clear_idx <= clear_idx + 1'b1;
                            state     <= clear_read;
                        end
                    end
                end
                dcache_pkg::clear_done: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Request, command and response payload
    // ------------------------------------------------------------------
    always_ff @(posedge clk100) begin
        if (req_valid && req_ready) begin
            req_addr_q  <= req_addr;
            req_wdata_q <= req_wdata;
            req_we_q    <= req_we;
        end
        case (state)
            lookup_check: begin
                if (hit) begin
                    rsp_data_q <= req_we_q ? '0 : pick_word(rd_line, req_offset);
                end else if (victim_dirty) begin
                    // Victim goes back under its own tag
                    mem.cmd_we    <= 1'b1;
                    mem.cmd_addr  <= {rd_tag, req_index};
                    mem.cmd_wdata <= rd_line;
                end else begin
                    mem.cmd_we   <= 1'b0;
                    mem.cmd_addr <= {req_tag, req_index};
                end
            end
            evict_wait: begin
                if (mem.done) begin
                    mem.cmd_we   <= 1'b0;
                    mem.cmd_addr <= {req_tag, req_index};
                end
            end
            refill_wait: begin
                if (mem.done) begin
                    rsp_data_q <= req_we_q ? '0 : pick_word(mem.rdata, req_offset);
                end
            end
            clear_check: begin
                if (victim_dirty) begin
                    mem.cmd_we    <= 1'b1;
                    mem.cmd_addr  <= {rd_tag, clear_idx};
                    mem.cmd_wdata <= rd_line;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: logic/dcache_top.sv
// Data cache top level with plain CPU and SDRAM ports
// Controller, line RAM and SDRAM link joined by two bundles
`timescale 1ns/100ps

module dcache_top import dcache_pkg::*; (
    input  logic       clk100,
    input  logic       reset,
    // CPU request
    input  logic       req_valid,
    output logic       req_ready,
    input  cpu_addr_t  req_addr,
    input  word_t      req_wdata,
    input  logic       req_we,
    // CPU response
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output word_t      rsp_data,
    // Cache clear
    input  logic       clear_valid,
    output logic       clear_ready,
    output logic       clear_done,
    // SDRAM controller
    output logic       sdc_start,
    output logic       sdc_we,
    output line_addr_t sdc_addr,
    output line_t      sdc_data,
    input  logic       sdc_done,
    input  line_t      sdc_q
);

    line_ram_if ram_bus ();
    mem_cmd_if  mem_bus ();

    // ------------------------------------------------------------------
    // Controller
    // ------------------------------------------------------------------
    dcache_ctrl i_ctrl (
        .clk100      (clk100),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_we      (req_we),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp_data    (rsp_data),
        .clear_valid (clear_valid),
        .clear_ready (clear_ready),
        .clear_done  (clear_done),
        .ram         (ram_bus.ctrl),
        .mem         (mem_bus.ctrl)
    );

    // Entry store
    line_ram i_ram (
        .clk100 (clk100),
        .ram    (ram_bus.ram)
    );

    // Memory side
    sdram_link i_link (
        .clk100    (clk100),
        .reset     (reset),
        .cmd       (mem_bus.link),
        .sdc_start (sdc_start),
        .sdc_we    (sdc_we),
        .sdc_addr  (sdc_addr),
        .sdc_data  (sdc_data),
        .sdc_done  (sdc_done),
        .sdc_q     (sdc_q)
    );

endmodule

// File: tb/dcache_checker.sv
// Concurrent assertions on the data cache top-level handshakes
// Bound into dcache_top
`timescale 1ns/100ps

module dcache_checker import dcache_pkg::*; (
    input logic  clk100,
    input logic  reset,
    input logic  req_ready,
    input logic  rsp_valid,
    input logic  rsp_ready,
    input word_t rsp_data,
    input logic  sdc_start,
    input logic  clear_done
);

    // Number of failed assertions
    int unsigned fail_count = 0;

    // Response held until the CPU takes it
    rsp_held: assert property (@(posedge clk100) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
    else begin
        $error("rsp_valid or rsp_data changed while rsp_ready was low");
        fail_count++;
    end

    // SDRAM start is a single pulse
    start_pulse: assert property (@(posedge clk100) disable iff (reset)
        sdc_start |=> !sdc_start)
    else begin
        $error("sdc_start was high for more than one cycle");
        fail_count++;
    end

    // No new request while a response is pending
    no_req_during_rsp: assert property (@(posedge clk100) disable iff (reset)
        rsp_valid |-> !req_ready)
    else begin
        $error("req_ready was high while rsp_valid was high");
        fail_count++;
    end

    clear_pulse: assert property (@(posedge clk100) disable iff (reset)
        clear_done |=> !clear_done)
    else begin
        $error("clear_done was high for more than one cycle");
        fail_count++;
    end

endmodule

bind dcache_top dcache_checker i_checker (.*);

// File: tb/dcache_tb.sv
// Data cache testbench with clock, reset and trace playback
// SDRAM line model with random latency, response back-pressure
// Shadow of written words for write-back prediction, compare tasks
`timescale 1ns/100ps

module dcache_tb import dcache_pkg::*; ();

    localparam word_t ADDR_MASK     = 32'h03FF_FFFF;
    // Unwritten SDRAM words read as their address XOR this
    localparam word_t INIT_XOR      = 32'hA5C3_0000;
    localparam int    REQ_TIMEOUT   = 50;
    localparam int    RSP_TIMEOUT   = 200;
    localparam int    CLEAR_TIMEOUT = 5000;

    logic       clk100;
    logic       reset;
    logic       req_valid;
    logic       req_ready;
    cpu_addr_t  req_addr;
    word_t      req_wdata;
    logic       req_we;
    logic       rsp_valid;
    logic       rsp_ready;
    word_t      rsp_data;
    logic       clear_valid;
    logic       clear_ready;
    logic       clear_done;
    logic       sdc_start;
    logic       sdc_we;
    line_addr_t sdc_addr;
    line_t      sdc_data;
    logic       sdc_done;
    line_t      sdc_q;

    // SDRAM contents and the words the CPU has written
    line_t       sdram [line_addr_t];
    word_t       shadow [cpu_addr_t];
    logic [15:0] lfsr = 16'd31;
    int          sdram_reads = 0;
    int          sdram_writes = 0;

    dcache_top i_dut (.*);

    always #2 clk100 = ~clk100;

    // ------------------------------------------------------------------
    // Random bits from x^16 + x^14 + x^13 + x^11 + 1
    // ------------------------------------------------------------------
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int lfsr_draw(int bits);
        int value;
        value = 0;
        for (int i = 0; i < bits; i++) begin
            value = (value << 1) | int'(lfsr_step());
        end
        return value;
    endfunction

    // ------------------------------------------------------------------
    // Expected memory contents
    // ------------------------------------------------------------------
    function automatic line_t initial_line(line_addr_t la);
        line_t line;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            line[k*WORD_BITS +: WORD_BITS] = cpu_addr_t'({la, offset_t'(k)}) ^ INIT_XOR;
        end
        return line;
    endfunction

    // Latest word the CPU should see at addr
    function automatic word_t expected_word(cpu_addr_t addr);
        cpu_addr_t key;
        key = addr & ADDR_MASK;
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return key ^ INIT_XOR;
    endfunction

    function automatic line_t expected_line(line_addr_t la);
        line_t line;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            line[k*WORD_BITS +: WORD_BITS] = expected_word(cpu_addr_t'({la, offset_t'(k)}));
        end
        return line;
    endfunction

    // ------------------------------------------------------------------
    // Failure and compare tasks
    // ------------------------------------------------------------------
    task automatic stop_on_failure(string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_line(line_addr_t la, line_t got);
        line_t exp;
        exp = expected_line(la);
        if (got !== exp) begin
            stop_on_failure($sformatf("ERROR sdc_data at line %h: got %h, expected %h",
                                      la, got, exp));
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            stop_on_failure($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // Inputs change and outputs are sampled half a ns after the edge
    task automatic next_cycle();
        @(posedge clk100);
        #0.5;
    endtask

    // Stale power-up entries that are valid and clean with tag 0
    task automatic fill_line_ram();
        entry_t entry;
        for (int i = 0; i < NUM_LINES; i++) begin
            entry = '0;
            entry[VALID_BIT] = 1'b1;
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
                entry[DATA_LSB + k*WORD_BITS +: WORD_BITS] = 32'hBAD0_0000 | word_t'(i*8 + k);
            end
            i_dut.i_ram.mem[i] = entry;
        end
    endtask

    // Handshake assertions of the bound checker
    always @(negedge clk100) begin
        if (i_dut.i_checker.fail_count != 0) begin
            stop_on_failure("A handshake assertion in the checker failed");
        end
    end

    // ------------------------------------------------------------------
    // CPU side
    // ------------------------------------------------------------------
    task automatic issue_request(logic we, cpu_addr_t addr, word_t wdata);
        int waited;
        req_valid = 1'b1;
        req_we    = we;
        req_addr  = addr;
        req_wdata = wdata;
        waited    = 0;
        while (!req_ready) begin
            if (waited == REQ_TIMEOUT) begin
                stop_on_failure("Timeout: the cache never raised req_ready");
            end
            next_cycle();
            waited++;
        end
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic take_response(word_t exp);
        int waited;
        int stall;
        waited = 0;
        while (!rsp_valid) begin
            if (waited == RSP_TIMEOUT) begin
                stop_on_failure("Timeout: no response arrived for the request");
            end
            next_cycle();
            waited++;
        end
        // Back-pressure for 0 to 3 cycles
        stall = lfsr_draw(2);
        repeat (stall) begin
            next_cycle();
            if (!rsp_valid || req_ready) begin
                stop_on_failure("Response dropped or new request taken during back-pressure");
            end
        end
        check_word("rsp_data", rsp_data, exp);
        rsp_ready = 1'b1;
        next_cycle();
        rsp_ready = 1'b0;
        if (rsp_valid) begin
            stop_on_failure("The same response was offered twice");
        end
    endtask

    task automatic run_clear();
        int waited;
        clear_valid = 1'b1;
        waited      = 0;
        while (!clear_ready) begin
            if (waited == REQ_TIMEOUT) begin
                stop_on_failure("Timeout: the cache never raised clear_ready");
            end
            next_cycle();
            waited++;
        end
        next_cycle();
        clear_valid = 1'b0;
        waited      = 0;
        while (!clear_done) begin
            if (waited == CLEAR_TIMEOUT) begin
                stop_on_failure("Timeout: the clear walk never finished");
            end
            next_cycle();
            waited++;
        end
        next_cycle();
    endtask

    // ------------------------------------------------------------------
    // SDRAM model
    // ------------------------------------------------------------------
    initial begin : sdram_model
        int delay;
        forever begin
            next_cycle();
            if (sdc_start) begin
                delay = 2 + lfsr_draw(3);
                if (sdc_we) begin
                    sdram_writes++;
                    check_line(sdc_addr, sdc_data);
                    sdram[sdc_addr] = sdc_data;
                end else begin
                    sdram_reads++;
                end
                repeat (delay) next_cycle();
                sdc_q    = sdram.exists(sdc_addr) ? sdram[sdc_addr] : initial_line(sdc_addr);
                sdc_done = 1'b1;
                next_cycle();
                sdc_done = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // Trace playback
    // ------------------------------------------------------------------
    initial begin : main
        int        fd;
        int        fields;
        int        ops;
        string     text;
        byte       op;
        cpu_addr_t addr;
        word_t     wdata;
        word_t     exp_data;
        int        exp_reads;
        int        exp_writes;
        int        reads_before;
        int        writes_before;

        clk100      = 1'b0;
        reset       = 1'b1;
        req_valid   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        req_we      = 1'b0;
        rsp_ready   = 1'b0;
        clear_valid = 1'b0;
        sdc_done    = 1'b0;
        sdc_q       = '0;
        ops         = 0;
        fill_line_ram();
        fd = $fopen("tb/dcache_trace.txt", "r");
        if (fd == 0) begin
            stop_on_failure("Cannot open the trace file tb/dcache_trace.txt");
        end
        repeat (2) @(posedge clk100);
        #0.5;
        reset = 1'b0;

        while ($fgets(text, fd) != 0) begin
            // Skip comments and blank lines
            if (text.len() < 2 || text.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(text, "%c %h %h %h %d %d",
                             op, addr, wdata, exp_data, exp_reads, exp_writes);
            if (fields != 6) begin
                stop_on_failure({"Malformed trace line: ", text});
            end
            reads_before  = sdram_reads;
            writes_before = sdram_writes;
            case (op)
                "C": run_clear();
                "R": begin
                    issue_request(1'b0, addr, '0);
                    take_response(exp_data);
                end
                "W": begin
                    shadow[addr & ADDR_MASK] = wdata;
                    issue_request(1'b1, addr, wdata);
                    take_response('0);
                end
                default: stop_on_failure({"Unknown operation in trace line: ", text});
            endcase
            // Hits, refills and write-backs show in the SDRAM traffic
            check_count("SDRAM reads", sdram_reads - reads_before, exp_reads);
            check_count("SDRAM writes", sdram_writes - writes_before, exp_writes);
            ops++;
        end
        $fclose(fd);

        if (ops == 0 || i_dut.i_checker.fail_count != 0) begin
            stop_on_failure("Empty trace or failed assertions in the checker");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: compile.f
logic/dcache_pkg.sv
logic/line_ram_if.sv
logic/mem_cmd_if.sv
logic/line_ram.sv
logic/sdram_link.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
tb/dcache_checker.sv
tb/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

dependencies: {}

sources:
  # Cache RTL, package first
  - logic/dcache_pkg.sv
  - logic/line_ram_if.sv
  - logic/mem_cmd_if.sv
  - logic/line_ram.sv
  - logic/sdram_link.sv
  - logic/dcache_ctrl.sv
  - logic/dcache_top.sv
  # Testbench and bound checker
  - target: test
    files:
      - tb/dcache_checker.sv
      - tb/dcache_tb.sv

// File: tb/dcache_trace.txt
# op addr wdata rdata refills writebacks
# op R read, W write, C clear; hex word address and data, counts in decimal
C 00000000 00000000 00000000 0 0
R 00000012 00000000 A5C30012 1 0
R 00000015 00000000 A5C30015 0 0
W 00000021 11112222 00000000 1 0
R 00000021 00000000 11112222 0 0
R 00000026 00000000 A5C30026 0 0
W 00000433 CAFE0001 00000000 1 0
R 00000830 00000000 A5C30830 1 1
R 00000433 00000000 CAFE0001 1 0
W 00000040 AAAA0040 00000000 1 0
W 00000047 AAAA0047 00000000 0 0
W 00000433 BBBB0433 00000000 0 0
W 0000FFF9 CCCC0009 00000000 1 0
W 00000022 DDDD0022 00000000 0 0
C 00000000 00000000 00000000 0 4
R 00000021 00000000 11112222 1 0
R 00000022 00000000 DDDD0022 0 0
R 00000433 00000000 BBBB0433 1 0
R 00000047 00000000 AAAA0047 1 0
R 0000FFF9 00000000 CCCC0009 1 0
R 00000012 00000000 A5C30012 1 0
